/* all.f */
hw/isa_pkg.sv
hw/pipe_pkg.sv
hw/decode_if.sv
hw/instr_decoder.sv
hw/operand_forward.sv
hw/hazard_tracker.sv
hw/flush_control.sv
hw/control_unit.sv
tests/control_unit_tb.sv

/* hw/control_unit.sv */
module control_unit (
    input  logic                 clk,
    input  logic                 reset,
    input  logic [7:0]           i_instr,
    input  logic                 i_branch_taken,
    output logic                 o_stall_f,
    output logic                 o_stall_d,
    output logic                 o_flush_f,
    output logic                 o_flush_d,
    output logic                 o_flush_ex,
    output logic                 o_reg_write,
    output isa_pkg::mem_read_e   o_mem_read,
    output logic                 o_mem_write,
    output isa_pkg::alu_op_e     o_alu_op,
    output isa_pkg::flag_mode_e  o_flag_change,
    output isa_pkg::reg_idx_t    o_reg_1,
    output isa_pkg::reg_idx_t    o_reg_2,
    output pipe_pkg::src_a_e     o_src_a,
    output pipe_pkg::src_b_e     o_src_b,
    output pipe_pkg::fwd_src_e   o_fwd_src_a,
    output pipe_pkg::fwd_src_e   o_fwd_src_b,
    output isa_pkg::reg_idx_t    o_wb_sel,
    output logic                 o_sp_inc,
    output logic                 o_sp_dec,
    output logic                 o_read_out,
    output isa_pkg::jmp_kind_e   o_jmp_chk,
    output logic                 o_store_pc,
    output logic                 o_return_flags,
    output logic                 o_wb_from_mem
);

    pipe_pkg::src_a_e     dec_src_a;
    pipe_pkg::src_b_e     dec_src_b;
    pipe_pkg::write_rec_t dec_rec;
    pipe_pkg::write_rec_t rec_ex;
    pipe_pkg::write_rec_t rec_mem;
    pipe_pkg::write_rec_t rec_wb;
    logic                 stall;

    decode_if op_if [2] ();  // Operand A, operand B

    instr_decoder u_dec (
        .i_instr        (i_instr),
        .o_reg_write    (o_reg_write),
        .o_mem_read     (o_mem_read),
        .o_mem_write    (o_mem_write),
        .o_alu_op       (o_alu_op),
        .o_flag_change  (o_flag_change),
        .o_reg_1        (o_reg_1),
        .o_reg_2        (o_reg_2),
        .o_src_a        (dec_src_a),
        .o_src_b        (dec_src_b),
        .o_wb_sel       (o_wb_sel),
        .o_sp_inc       (o_sp_inc),
        .o_sp_dec       (o_sp_dec),
        .o_read_out     (o_read_out),
        .o_jmp_chk      (o_jmp_chk),
        .o_store_pc     (o_store_pc),
        .o_return_flags (o_return_flags),
        .o_wb_from_mem  (o_wb_from_mem),
        .opa            (op_if[0]),
        .opb            (op_if[1])
    );

    for (genvar g = 0; g < 2; g++) begin : g_fwd
        operand_forward u_fwd (
            .res       (op_if[g]),
            .i_rec_ex  (rec_ex),
            .i_rec_mem (rec_mem),
            .i_rec_wb  (rec_wb)
        );
    end

    assign dec_rec = '{from_mem: o_wb_from_mem, writes: o_reg_write, dest: o_wb_sel};

    hazard_tracker u_haz (
        .clk           (clk),
        .reset         (reset),
        .i_stall_req_a (op_if[0].stall_req),
        .i_stall_req_b (op_if[1].stall_req),
        .i_dec_rec     (dec_rec),
        .o_stall       (stall),
        .o_rec_ex      (rec_ex),
        .o_rec_mem     (rec_mem),
        .o_rec_wb      (rec_wb)
    );

    flush_control u_flush (
        .clk            (clk),
        .reset          (reset),
        .i_jmp_chk      (o_jmp_chk),
        .i_stall        (stall),
        .i_branch_taken (i_branch_taken),
        .o_flush_f      (o_flush_f),
        .o_flush_d      (o_flush_d),
        .o_flush_ex     (o_flush_ex)
    );

    // ----------------------------------------
    // Operand source after forwarding
    // ----------------------------------------
    assign o_src_a     = op_if[0].fwd_hit ? pipe_pkg::SRCA_FWD : dec_src_a;
    assign o_src_b     = op_if[1].fwd_hit ? pipe_pkg::SRCB_FWD : dec_src_b;
    assign o_fwd_src_a = op_if[0].fwd_src;
    assign o_fwd_src_b = op_if[1].fwd_src;

    assign o_stall_f = stall;  // Fetch and decode always hold together
    assign o_stall_d = stall;

endmodule

/* hw/decode_if.sv */
interface decode_if;

    logic               uses_reg;   // Operand comes from the register file
    isa_pkg::reg_idx_t  reg_sel;
    logic               fwd_hit;
    pipe_pkg::fwd_src_e fwd_src;
    logic               stall_req;  // Load-use on this operand

    modport decoder (
        output uses_reg,
        output reg_sel
    );

    modport resolver (
        input  uses_reg,
        input  reg_sel,
        output fwd_hit,
        output fwd_src,
        output stall_req
    );

endinterface

/* hw/flush_control.sv */
module flush_control (
    input  logic               clk,
    input  logic               reset,
    input  isa_pkg::jmp_kind_e i_jmp_chk,
    input  logic               i_stall,
    input  logic               i_branch_taken,
    output logic               o_flush_f,
    output logic               o_flush_d,
    output logic               o_flush_ex
);

    pipe_pkg::flush_state_e state;
    pipe_pkg::flush_state_e state_nxt;

    // ----------------------------------------
    // Jump FSM
    // ----------------------------------------
    always_comb begin
        state_nxt = state;
        case (state)
            pipe_pkg::FL_IDLE: begin
                if (!i_stall) begin  // Stalled jump waits to be re-presented
                    case (i_jmp_chk)
                        isa_pkg::JMP_JMP: state_nxt = pipe_pkg::FL_UNCOND;
                        isa_pkg::JMP_RET: state_nxt = pipe_pkg::FL_DELAY1;
                        isa_pkg::JMP_JZ, isa_pkg::JMP_JN, isa_pkg::JMP_JC,
                        isa_pkg::JMP_JV, isa_pkg::JMP_LOOP: state_nxt = pipe_pkg::FL_COND;
                        default: state_nxt = pipe_pkg::FL_IDLE;
                    endcase
                end
            end
            pipe_pkg::FL_DELAY1: state_nxt = pipe_pkg::FL_DELAY2;  // Return address from memory
            default:             state_nxt = pipe_pkg::FL_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= pipe_pkg::FL_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    assign o_flush_f  = (state == pipe_pkg::FL_UNCOND) || (state == pipe_pkg::FL_DELAY2) ||
                        ((state == pipe_pkg::FL_COND) && i_branch_taken);
    assign o_flush_d  = o_flush_f;                       // Both front stages hold wrong path
    assign o_flush_ex = (state == pipe_pkg::FL_DELAY2);  // RET also squashes EX

    a_ex_with_f: assert property (@(posedge clk) disable iff (reset)
        o_flush_ex |-> o_flush_f)
        else $error("EX flushed without fetch flush");

endmodule

/* hw/hazard_tracker.sv */
module hazard_tracker (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 i_stall_req_a,
    input  logic                 i_stall_req_b,
    input  pipe_pkg::write_rec_t i_dec_rec,
    output logic                 o_stall,
    output pipe_pkg::write_rec_t o_rec_ex,
    output pipe_pkg::write_rec_t o_rec_mem,
    output pipe_pkg::write_rec_t o_rec_wb
);

    assign o_stall = i_stall_req_a | i_stall_req_b;

    // ----------------------------------------
    // Write record shift chain
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            o_rec_ex  <= '0;
            o_rec_mem <= '0;
            o_rec_wb  <= '0;
        end else begin
            o_rec_ex  <= o_stall ? '0 : i_dec_rec;  // Bubble while decode holds
            o_rec_mem <= o_rec_ex;
            o_rec_wb  <= o_rec_mem;
        end
    end

    // Only a load still in EX may hold up decode
    a_stall_on_load: assert property (@(posedge clk) disable iff (reset)
        o_stall |-> (o_rec_ex.writes && o_rec_ex.from_mem))
        else $error("stall without a load in EX");

endmodule

/* hw/instr_decoder.sv */
module instr_decoder (
    input  logic [7:0]           i_instr,
    output logic                 o_reg_write,
    output isa_pkg::mem_read_e   o_mem_read,
    output logic                 o_mem_write,
    output isa_pkg::alu_op_e     o_alu_op,
    output isa_pkg::flag_mode_e  o_flag_change,
    output isa_pkg::reg_idx_t    o_reg_1,
    output isa_pkg::reg_idx_t    o_reg_2,
    output pipe_pkg::src_a_e     o_src_a,
    output pipe_pkg::src_b_e     o_src_b,
    output isa_pkg::reg_idx_t    o_wb_sel,
    output logic                 o_sp_inc,
    output logic                 o_sp_dec,
    output logic                 o_read_out,
    output isa_pkg::jmp_kind_e   o_jmp_chk,
    output logic                 o_store_pc,
    output logic                 o_return_flags,
    output logic                 o_wb_from_mem,
    decode_if.decoder            opa,
    decode_if.decoder            opb
);

    isa_pkg::opcode_e  opcode;
    isa_pkg::reg_idx_t ra;
    isa_pkg::reg_idx_t rb;

    assign opcode = isa_pkg::opcode_e'(i_instr[7:4]);
    assign ra     = i_instr[3:2];
    assign rb     = i_instr[1:0];  // Also selects the sub-operation

    // ----------------------------------------
    // Control table
    // ----------------------------------------
    always_comb begin
        o_reg_write    = 1'b0;
        o_mem_read     = isa_pkg::MEMRD_ALU;
        o_mem_write    = 1'b0;
        o_alu_op       = isa_pkg::ALU_MOV_A;
        o_flag_change  = isa_pkg::FLAG_KEEP;
        o_reg_1        = ra;
        o_reg_2        = rb;
        o_src_a        = pipe_pkg::SRCA_IMM;
        o_src_b        = pipe_pkg::SRCB_PC;
        o_wb_sel       = ra;
        o_sp_inc       = 1'b0;
        o_sp_dec       = 1'b0;
        o_read_out     = 1'b0;
        o_jmp_chk      = isa_pkg::JMP_NONE;
        o_store_pc     = 1'b0;
        o_return_flags = 1'b0;
        o_wb_from_mem  = 1'b0;
        case (opcode)
            isa_pkg::OPC_MOV: begin
                o_reg_write = 1'b1;
                o_alu_op    = isa_pkg::ALU_MOV_B;
                o_src_b     = pipe_pkg::SRCB_REG;
            end
            isa_pkg::OPC_ADD, isa_pkg::OPC_SUB, isa_pkg::OPC_AND, isa_pkg::OPC_OR: begin
                o_reg_write = 1'b1;
                o_src_a     = pipe_pkg::SRCA_REG;
                o_src_b     = pipe_pkg::SRCB_REG;
                case (opcode)
                    isa_pkg::OPC_ADD: o_alu_op = isa_pkg::ALU_ADD;
                    isa_pkg::OPC_SUB: o_alu_op = isa_pkg::ALU_SUB;
                    isa_pkg::OPC_AND: o_alu_op = isa_pkg::ALU_AND;
                    default:          o_alu_op = isa_pkg::ALU_OR;
                endcase
                o_flag_change = (opcode == isa_pkg::OPC_ADD || opcode == isa_pkg::OPC_SUB) ?
                                isa_pkg::FLAG_ALL : isa_pkg::FLAG_ZN;
            end
            isa_pkg::OPC_SHIFT: begin
                o_flag_change = isa_pkg::FLAG_ALL;
                case (rb)
                    2'd0:    o_alu_op = isa_pkg::ALU_RLC;
                    2'd1:    o_alu_op = isa_pkg::ALU_RRC;
                    2'd2:    o_alu_op = isa_pkg::ALU_SETC;
                    default: o_alu_op = isa_pkg::ALU_CLRC;
                endcase
                if (!rb[1]) begin  // Rotates write back
                    o_reg_write = 1'b1;
                    o_src_a     = pipe_pkg::SRCA_REG;
                end
            end
            isa_pkg::OPC_STACK_IO: begin
                case (rb)
                    2'd0: begin  // PUSH
                        o_src_a     = pipe_pkg::SRCA_REG;
                        o_mem_write = 1'b1;
                        o_sp_dec    = 1'b1;
                        o_reg_2     = isa_pkg::SP_REG;
                    end
                    2'd1: begin  // POP
                        o_reg_write   = 1'b1;
                        o_mem_read    = isa_pkg::MEMRD_MEM;
                        o_sp_inc      = 1'b1;
                        o_reg_2       = isa_pkg::SP_REG;
                        o_wb_from_mem = 1'b1;
                    end
                    2'd2: begin  // OUT
                        o_src_a    = pipe_pkg::SRCA_REG;
                        o_read_out = 1'b1;
                    end
                    default: begin  // IN
                        o_reg_write = 1'b1;
                        o_src_a     = pipe_pkg::SRCA_INPORT;
                    end
                endcase
            end
            isa_pkg::OPC_UNARY: begin
                o_reg_write = 1'b1;
                o_src_a     = pipe_pkg::SRCA_REG;
                case (rb)
                    2'd0:    o_alu_op = isa_pkg::ALU_NOT;
                    2'd1:    o_alu_op = isa_pkg::ALU_NEG;
                    2'd2:    o_alu_op = isa_pkg::ALU_INC;
                    default: o_alu_op = isa_pkg::ALU_DEC;
                endcase
                o_flag_change = (rb == 2'd0) ? isa_pkg::FLAG_ZN : isa_pkg::FLAG_ALL;
            end
            isa_pkg::OPC_JCOND: begin
                o_src_a = pipe_pkg::SRCA_REG;  // Target in ra
                case (rb)
                    2'd0:    o_jmp_chk = isa_pkg::JMP_JZ;
                    2'd1:    o_jmp_chk = isa_pkg::JMP_JN;
                    2'd2:    o_jmp_chk = isa_pkg::JMP_JC;
                    default: o_jmp_chk = isa_pkg::JMP_JV;
                endcase
            end
            isa_pkg::OPC_LOOP: begin
                o_reg_write = 1'b1;
                o_src_a     = pipe_pkg::SRCA_REG;
                o_alu_op    = isa_pkg::ALU_DEC_A;
                o_jmp_chk   = isa_pkg::JMP_LOOP;
            end
            isa_pkg::OPC_JUMP: begin
                case (rb)
                    2'd0: begin  // JMP
                        o_src_a   = pipe_pkg::SRCA_REG;
                        o_jmp_chk = isa_pkg::JMP_JMP;
                    end
                    2'd1: begin  // CALL
                        o_src_a     = pipe_pkg::SRCA_REG;
                        o_jmp_chk   = isa_pkg::JMP_JMP;
                        o_store_pc  = 1'b1;
                        o_mem_write = 1'b1;
                        o_sp_dec    = 1'b1;
                    end
                    default: begin  // RET, RTI
                        o_jmp_chk      = isa_pkg::JMP_RET;
                        o_mem_read     = isa_pkg::MEMRD_MEM;
                        o_sp_inc       = 1'b1;
                        o_return_flags = (rb == 2'd3);
                    end
                endcase
            end
            isa_pkg::OPC_LDI_LDD_STD: begin
                case (rb)
                    2'd0: begin  // LDI
                        o_reg_write = 1'b1;
                    end
                    2'd1: begin  // LDD
                        o_reg_write   = 1'b1;
                        o_mem_read    = isa_pkg::MEMRD_MEM;
                        o_wb_from_mem = 1'b1;
                    end
                    default: begin  // STD
                        o_mem_write = 1'b1;
                        o_reg_2     = ra;
                        o_src_b     = pipe_pkg::SRCB_REG;
                    end
                endcase
            end
            isa_pkg::OPC_LOAD_IND: begin
                o_reg_write   = 1'b1;
                o_reg_1       = rb;  // Address register
                o_src_a       = pipe_pkg::SRCA_REG;
                o_mem_read    = isa_pkg::MEMRD_MEM;
                o_wb_from_mem = 1'b1;
            end
            isa_pkg::OPC_STORE_IND: begin
                o_mem_write = 1'b1;
                o_reg_1     = rb;
                o_reg_2     = ra;  // Data register
                o_src_a     = pipe_pkg::SRCA_REG;
                o_src_b     = pipe_pkg::SRCB_REG;
            end
            default: begin
            end
        endcase
    end

    assign opa.uses_reg = (o_src_a == pipe_pkg::SRCA_REG);
    assign opa.reg_sel  = o_reg_1;
    assign opb.uses_reg = (o_src_b == pipe_pkg::SRCB_REG);
    assign opb.reg_sel  = o_reg_2;

endmodule

/* hw/isa_pkg.sv */
package isa_pkg;

    // ----------------------------------------
    // Instruction fields
    // ----------------------------------------
    typedef enum logic [3:0] {
        OPC_NOP         = 4'd0,
        OPC_MOV         = 4'd1,
        OPC_ADD         = 4'd2,
        OPC_SUB         = 4'd3,
        OPC_AND         = 4'd4,
        OPC_OR          = 4'd5,
        OPC_SHIFT       = 4'd6,   // RLC, RRC, SETC, CLRC
        OPC_STACK_IO    = 4'd7,   // PUSH, POP, OUT, IN
        OPC_UNARY       = 4'd8,   // NOT, NEG, INC, DEC
        OPC_JCOND       = 4'd9,
        OPC_LOOP        = 4'd10,
        OPC_JUMP        = 4'd11,  // JMP, CALL, RET, RTI
        OPC_LDI_LDD_STD = 4'd12,  // Two-byte forms
        OPC_LOAD_IND    = 4'd13,
        OPC_STORE_IND   = 4'd14
    } opcode_e;

    typedef logic [1:0] reg_idx_t;

    localparam reg_idx_t SP_REG = 2'd3;  // R3 doubles as stack pointer

    // ----------------------------------------
    // Datapath control encodings
    // ----------------------------------------
    typedef enum logic [3:0] {
        ALU_MOV_A = 4'd0,  ALU_MOV_B = 4'd1,  ALU_ADD  = 4'd2,  ALU_SUB   = 4'd3,
        ALU_AND   = 4'd4,  ALU_OR    = 4'd5,  ALU_DEC  = 4'd6,  ALU_INC   = 4'd7,
        ALU_NEG   = 4'd8,  ALU_NOT   = 4'd9,  ALU_RLC  = 4'd10, ALU_RRC   = 4'd11,
        ALU_SETC  = 4'd12, ALU_CLRC  = 4'd13, ALU_DEC_A = 4'd14
    } alu_op_e;

    typedef enum logic [2:0] {
        JMP_NONE = 3'd0, JMP_JZ  = 3'd1, JMP_JN  = 3'd2, JMP_JC   = 3'd3,
        JMP_JV   = 3'd4, JMP_JMP = 3'd5, JMP_RET = 3'd6, JMP_LOOP = 3'd7
    } jmp_kind_e;

    typedef enum logic [1:0] {
        FLAG_KEEP = 2'd0,
        FLAG_ZN   = 2'd1,  // Zero and negative only
        FLAG_ALL  = 2'd2
    } flag_mode_e;

    typedef enum logic [1:0] {
        MEMRD_ALU = 2'd0,
        MEMRD_MEM = 2'd1
    } mem_read_e;

endpackage

/* hw/operand_forward.sv */
module operand_forward (
    decode_if.resolver           res,
    input  pipe_pkg::write_rec_t i_rec_ex,
    input  pipe_pkg::write_rec_t i_rec_mem,
    input  pipe_pkg::write_rec_t i_rec_wb
);

    logic hit_ex;
    logic hit_mem;
    logic hit_wb;

    assign hit_ex  = i_rec_ex.writes  && (i_rec_ex.dest  == res.reg_sel);
    assign hit_mem = i_rec_mem.writes && (i_rec_mem.dest == res.reg_sel);
    assign hit_wb  = i_rec_wb.writes  && (i_rec_wb.dest  == res.reg_sel);

    // Youngest matching write wins
    always_comb begin
        res.fwd_hit   = 1'b0;
        res.fwd_src   = pipe_pkg::FWD_EX;
        res.stall_req = 1'b0;
        if (res.uses_reg) begin
            if (hit_ex) begin
                res.stall_req = i_rec_ex.from_mem;   // Load data not ready yet
                res.fwd_hit   = !i_rec_ex.from_mem;
            end else if (hit_mem) begin
                res.fwd_hit = 1'b1;
                res.fwd_src = pipe_pkg::FWD_MEM;
            end else if (hit_wb) begin
                res.fwd_hit = 1'b1;
                res.fwd_src = pipe_pkg::FWD_WB;
            end
        end
    end

    always_comb begin
        a_hit_or_stall: assert (!(res.fwd_hit && res.stall_req))
            else $error("operand both forwarded and stalled");
    end

endmodule

/* hw/pipe_pkg.sv */
package pipe_pkg;

    typedef enum logic [1:0] {
        SRCA_REG    = 2'd0,
        SRCA_IMM    = 2'd1,
        SRCA_FWD    = 2'd2,
        SRCA_INPORT = 2'd3
    } src_a_e;

    typedef enum logic [1:0] {
        SRCB_REG = 2'd0,
        SRCB_PC  = 2'd1,
        SRCB_FWD = 2'd2
    } src_b_e;

    typedef enum logic [1:0] {
        FWD_EX  = 2'd0,  // ALU result
        FWD_MEM = 2'd1,  // Memory stage output
        FWD_WB  = 2'd2   // Write-back value
    } fwd_src_e;

    // One in-flight register write
    typedef struct packed {
        logic              from_mem;
        logic              writes;
        isa_pkg::reg_idx_t dest;
    } write_rec_t;

    typedef enum logic [2:0] {
        FL_IDLE   = 3'd0,
        FL_UNCOND = 3'd1,
        FL_DELAY1 = 3'd2,
        FL_DELAY2 = 3'd3,
        FL_COND   = 3'd4
    } flush_state_e;

endpackage

/* run_sim.sh */
#!/bin/sh
# Verilator build and run of control_unit_tb

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module control_unit_tb \
    -f all.f -Mdir obj_dir -o control_unit_tb_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/control_unit_tb_sim > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if grep -q "Errors found" sim.log; then
    exit 1
fi
if ! grep -q "No errors" sim.log; then
    echo "Simulation ended without a result line"
    exit 1
fi
exit 0

/* tests/control_cases.txt */
// id instr taken | expected: stall src_a src_b fwd_a fwd_b reg_wr wb_sel alu mem_rd mem_wr
// flush_f flush_d flush_ex ; all hex, ff leaves a column unchecked, id 00 ends the list
// Test 1: reset state and NOP defaults
01 00 00 00 01 ff ff ff 00 ff ff 00 00 00 00 00
// Test 2: control table (ADD, SUB, INC, MOV, IN, LDI, STI, POP)
02 26 00 00 ff ff ff ff 01 01 02 00 00 00 00 00
02 3b 00 00 ff ff ff ff 01 02 03 00 00 00 00 00
02 8a 00 00 ff ff ff ff 01 02 07 00 00 00 00 00
02 1a 00 00 ff ff ff ff 01 02 ff 00 00 00 00 00
02 7f 00 00 03 ff ff ff 01 03 ff 00 00 00 00 00
02 d5 00 00 ff ff ff ff 01 01 ff 01 00 00 00 00
02 ea 00 00 ff ff ff ff 00 ff ff ff 01 00 00 00
02 75 00 00 ff ff ff ff 01 01 ff 01 00 00 00 00
// Test 3: drain, then forwarding from WB, MEM and EX
03 00 00 00 ff ff ff ff 00 ff ff 00 00 00 00 00
03 00 00 00 ff ff ff ff 00 ff ff 00 00 00 00 00
03 00 00 00 ff ff ff ff 00 ff ff 00 00 00 00 00
03 25 00 00 00 00 ff ff 01 01 02 00 00 00 00 00
03 2a 00 00 00 00 ff ff 01 02 02 00 00 00 00 00
03 2f 00 00 00 00 ff ff 01 03 02 00 00 00 00 00
03 25 00 00 02 02 02 02 01 01 02 00 00 00 00 00
03 2f 00 00 02 02 01 01 01 03 02 00 00 00 00 00
03 2f 00 00 02 02 00 00 01 03 02 00 00 00 00 00
03 2f 00 00 02 02 00 00 01 03 02 00 00 00 00 00
// Test 4: load-use stall for one cycle, then MEM forward
04 da 00 00 ff ff ff ff 01 02 ff 01 00 00 00 00
04 2a 00 01 00 00 ff ff 01 02 02 00 00 00 00 00
04 2a 00 00 02 02 01 01 01 02 02 00 00 00 00 00
04 00 00 00 ff ff ff ff 00 ff ff 00 00 00 00 00
// Test 5: JMP, RET, and a JMP ignored while busy
05 b0 00 00 ff ff ff ff ff ff ff ff ff 00 00 00
05 00 00 00 ff ff ff ff 00 ff ff 00 00 01 01 00
05 00 00 00 ff ff ff ff 00 ff ff 00 00 00 00 00
05 ba 00 00 ff ff ff ff ff ff ff ff ff 00 00 00
05 00 00 00 ff ff ff ff 00 ff ff 00 00 00 00 00
05 00 00 00 ff ff ff ff 00 ff ff 00 00 01 01 01
05 00 00 00 ff ff ff ff 00 ff ff 00 00 00 00 00
05 b0 00 00 ff ff ff ff ff ff ff ff ff 00 00 00
05 b0 00 00 ff ff ff ff ff ff ff ff ff 01 01 00
05 00 00 00 ff ff ff ff 00 ff ff 00 00 00 00 00
// Test 6: JZ taken, then JZ not taken
06 90 01 00 ff ff ff ff ff ff ff ff ff 00 00 00
06 00 01 00 ff ff ff ff 00 ff ff 00 00 01 01 00
06 00 00 00 ff ff ff ff 00 ff ff 00 00 00 00 00
06 90 00 00 ff ff ff ff ff ff ff ff ff 00 00 00
06 00 00 00 ff ff ff ff 00 ff ff 00 00 00 00 00
06 00 01 00 ff ff ff ff 00 ff ff 00 00 00 00 00
// End of cases
00

/* tests/control_unit_tb.sv */
module control_unit_tb;

    localparam int         CLK_PERIOD  = 20;
    localparam int         CHECK_DELAY = 18;     // Just ahead of the next rising edge
    localparam int         NUM_COLS    = 16;     // Tokens per case line
    localparam int         MAX_CASES   = 64;
    localparam logic [7:0] ANY_VALUE   = 8'hff;  // Column not checked on this line

    logic       clk;
    logic       reset;
    logic [7:0] i_instr;
    logic       i_branch_taken;

    logic       o_stall_f;
    logic       o_stall_d;
    logic       o_flush_f;
    logic       o_flush_d;
    logic       o_flush_ex;
    logic       o_reg_write;
    logic [1:0] o_mem_read;
    logic       o_mem_write;
    logic [3:0] o_alu_op;
    logic [1:0] o_flag_change;
    logic [1:0] o_reg_1;
    logic [1:0] o_reg_2;
    logic [1:0] o_src_a;
    logic [1:0] o_src_b;
    logic [1:0] o_fwd_src_a;
    logic [1:0] o_fwd_src_b;
    logic [1:0] o_wb_sel;
    logic       o_sp_inc;
    logic       o_sp_dec;
    logic       o_read_out;
    logic [2:0] o_jmp_chk;
    logic       o_store_pc;
    logic       o_return_flags;
    logic       o_wb_from_mem;

    logic [7:0] case_mem [MAX_CASES * NUM_COLS];  // One case line per NUM_COLS words

    int n_cases;
    int line_idx;
    int check_count;
    int fail_count;
    int test_count;
    int test_checks;
    int test_fails;
    int cur_test;

    control_unit dut_i (
        .clk            (clk),
        .reset          (reset),
        .i_instr        (i_instr),
        .i_branch_taken (i_branch_taken),
        .o_stall_f      (o_stall_f),
        .o_stall_d      (o_stall_d),
        .o_flush_f      (o_flush_f),
        .o_flush_d      (o_flush_d),
        .o_flush_ex     (o_flush_ex),
        .o_reg_write    (o_reg_write),
        .o_mem_read     (o_mem_read),
        .o_mem_write    (o_mem_write),
        .o_alu_op       (o_alu_op),
        .o_flag_change  (o_flag_change),
        .o_reg_1        (o_reg_1),
        .o_reg_2        (o_reg_2),
        .o_src_a        (o_src_a),
        .o_src_b        (o_src_b),
        .o_fwd_src_a    (o_fwd_src_a),
        .o_fwd_src_b    (o_fwd_src_b),
        .o_wb_sel       (o_wb_sel),
        .o_sp_inc       (o_sp_inc),
        .o_sp_dec       (o_sp_dec),
        .o_read_out     (o_read_out),
        .o_jmp_chk      (o_jmp_chk),
        .o_store_pc     (o_store_pc),
        .o_return_flags (o_return_flags),
        .o_wb_from_mem  (o_wb_from_mem)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ----------------------------------------
    // Case handling
    // ----------------------------------------
    function automatic int count_cases();
        int n;
        n = 0;
        while (n < MAX_CASES && case_mem[n * NUM_COLS] inside {[8'h01:8'hfe]}) begin
            n++;  // Id 00 marks the end
        end
        return n;
    endfunction

    task automatic apply_case(input int base);
        i_instr        <= case_mem[base + 1];
        i_branch_taken <= case_mem[base + 2][0];
    endtask

    task automatic check_field(input string name, input logic [7:0] actual,
                               input logic [7:0] expected);
        if (expected != ANY_VALUE) begin
            check_count++;
            test_checks++;
            assert (actual == expected)
                else begin
                    $display("Mismatch at time %0t: test %0d case %0d, %s is %0h, expected %0h",
                             $time, cur_test, line_idx + 1, name, actual, expected);
                    fail_count++;
                    test_fails++;
                end
        end
    endtask

    // Fields the case file has no column for, known per instruction
    task automatic check_decode(input logic [7:0] instr);
        logic       known;
        logic [7:0] exp_flag;
        logic [7:0] exp_jmp;
        logic [7:0] exp_from_mem;
        logic [7:0] exp_sp_inc;
        logic [7:0] exp_reg_1;
        logic [7:0] exp_reg_2;
        known        = 1'b1;
        exp_flag     = 8'd0;  // KEEP
        exp_jmp      = 8'd0;  // NONE
        exp_from_mem = 8'd0;
        exp_sp_inc   = 8'd0;
        exp_reg_1    = ANY_VALUE;
        exp_reg_2    = ANY_VALUE;
        case (instr)
            8'h00, 8'h1a, 8'h7f, 8'hea: begin
            end
            8'h25, 8'h26, 8'h2a, 8'h2f, 8'h3b: begin
                exp_flag  = 8'd2;  // ALL
                exp_reg_1 = {6'd0, instr[3:2]};
                exp_reg_2 = {6'd0, instr[1:0]};
            end
            8'h8a: exp_flag = 8'd2;
            8'hd5, 8'hda: exp_from_mem = 8'd1;
            8'h75: begin
                exp_from_mem = 8'd1;
                exp_sp_inc   = 8'd1;
            end
            8'hb0: exp_jmp = 8'd5;
            8'hba: begin
                exp_jmp    = 8'd6;
                exp_sp_inc = 8'd1;
            end
            8'h90: exp_jmp = 8'd1;
            default: known = 1'b0;
        endcase
        if (known) begin
            check_field("o_flag_change", o_flag_change, exp_flag);
            check_field("o_jmp_chk", o_jmp_chk, exp_jmp);
            check_field("o_wb_from_mem", o_wb_from_mem, exp_from_mem);
            check_field("o_sp_inc", o_sp_inc, exp_sp_inc);
            check_field("o_sp_dec", o_sp_dec, 8'd0);
            check_field("o_read_out", o_read_out, 8'd0);
            check_field("o_store_pc", o_store_pc, 8'd0);
            check_field("o_return_flags", o_return_flags, 8'd0);
            check_field("o_reg_1", o_reg_1, exp_reg_1);
            check_field("o_reg_2", o_reg_2, exp_reg_2);
        end
    endtask

    task automatic check_case(input int base);
        check_field("o_stall_d", o_stall_d, case_mem[base + 3]);
        check_field("o_stall_f", o_stall_f, case_mem[base + 3]);  // Moves with decode stall
        check_field("o_src_a", o_src_a, case_mem[base + 4]);
        check_field("o_src_b", o_src_b, case_mem[base + 5]);
        check_field("o_fwd_src_a", o_fwd_src_a, case_mem[base + 6]);
        check_field("o_fwd_src_b", o_fwd_src_b, case_mem[base + 7]);
        check_field("o_reg_write", o_reg_write, case_mem[base + 8]);
        check_field("o_wb_sel", o_wb_sel, case_mem[base + 9]);
        check_field("o_alu_op", o_alu_op, case_mem[base + 10]);
        check_field("o_mem_read", o_mem_read, case_mem[base + 11]);
        check_field("o_mem_write", o_mem_write, case_mem[base + 12]);
        check_field("o_flush_f", o_flush_f, case_mem[base + 13]);
        check_field("o_flush_d", o_flush_d, case_mem[base + 14]);
        check_field("o_flush_ex", o_flush_ex, case_mem[base + 15]);
        check_decode(case_mem[base + 1]);
    endtask

    task automatic close_test();
        $display("Test %0d: %0d checks, %0d failed", cur_test, test_checks, test_fails);
    endtask

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------
    initial begin
        clk            = 1'b0;
        reset          = 1'b1;
        i_instr        = 8'h00;
        i_branch_taken = 1'b0;
        check_count    = 0;
        fail_count     = 0;
        test_count     = 0;
        test_checks    = 0;
        test_fails     = 0;
        cur_test       = -1;
        $readmemh("tests/control_cases.txt", case_mem);
        n_cases = count_cases();
        if (n_cases == 0) begin
            $display("No test cases could be read from tests/control_cases.txt");
            $display("Errors found");
            $finish;
        end else begin
            repeat (3) @(posedge clk);
            reset <= 1'b0;
            for (line_idx = 0; line_idx < n_cases; line_idx++) begin
                if (int'(case_mem[line_idx * NUM_COLS]) != cur_test) begin
                    if (cur_test >= 0) begin
                        close_test();
                    end
                    cur_test    = case_mem[line_idx * NUM_COLS];
                    test_checks = 0;
                    test_fails  = 0;
                    test_count++;
                end
                apply_case(line_idx * NUM_COLS);
                #(CHECK_DELAY);
                check_case(line_idx * NUM_COLS);
                @(posedge clk);
            end
            close_test();
            $display("Tests run: %0d, checks: %0d, failed checks: %0d",
                     test_count, check_count, fail_count);
            if (fail_count == 0) begin
                $display("No errors");
            end else begin
                $display("Errors found");
            end
            $finish;
        end
    end

    // Watchdog sized from the case count
    initial begin
        wait (n_cases > 0);
        #((n_cases + 10) * 2 * CLK_PERIOD);
        $display("Timeout: the case sequence did not finish in the time allowed");
        $display("Errors found");
        $finish;
    end

endmodule
